// ==== compile.f ====
+incdir+include
src/mem_stage_pkg.sv
src/mem_req.sv
src/dcache.sv
src/main_mem.sv
src/mem_resp.sv
src/mem_stage_top.sv
testbench/tb_mem_stage.sv

// ==== include/mem_stage_defines.svh ====
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// cache geometry
// words per line, index from addr[7:4]
`define MEM_LINE_WORDS 4
`define MEM_SETS 16

// backing memory depth in words, addresses wrap
`define MEM_WORDS 1024
// cycles from bus req to ack
`define MEM_LATENCY 3

// access width codes, 01 falls back to word
`define W_BYTE 2'b00
`define W_HALF 2'b10
`define W_WORD 2'b11

// exception codes
`define EXC_NONE 7'd0
`define EXC_ALE 7'd9

`endif

// ==== src/dcache.sv ====
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module dcache (
    input  logic                       clk,
    input  logic                       arst_n,
    input  mem_stage_pkg::cache_req_t  creq,
    output logic                       data_valid,
    output logic [31:0]                r_data,
    output mem_stage_pkg::bus_req_t    bus,
    input  logic                       bus_ack,
    input  logic [31:0]                bus_rdata
);
    import mem_stage_pkg::*;

    localparam int IW = $clog2(`MEM_SETS);
    localparam int OW = $clog2(`MEM_LINE_WORDS);
    localparam int TW = 32 - IW - OW - 2;
    localparam logic [OW-1:0] LAST = OW'(`MEM_LINE_WORDS - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL,
        S_WRITE
    } state_t;

    state_t              state;
    cache_req_t          rq;
    logic [`MEM_SETS-1:0] vld;
    logic [TW-1:0]       tag_q [`MEM_SETS];
    logic [31:0]         data_q [`MEM_SETS][`MEM_LINE_WORDS];
    logic [OW-1:0]       fill_cnt;
    logic [OW-1:0]       fill_next;
    logic [IW-1:0]       idx;
    logic [TW-1:0]       tag;
    logic [OW-1:0]       wsel;
    logic                hit;
    logic                accept;

    // split the held address
    assign tag  = rq.addr[31 -: TW];
    assign idx  = rq.addr[OW+2 +: IW];
    assign wsel = rq.addr[2 +: OW];
    assign hit  = vld[idx] && (tag_q[idx] == tag);

    // completion, read hit in lookup or write ack
    always_comb begin
        data_valid = 1'b0;
        case (state)
            S_LOOKUP: data_valid = !rq.op && hit;
            S_WRITE:  data_valid = bus_ack;
            default:  data_valid = 1'b0;
        endcase
    end

    // a new request only when idle or finishing the current one
    assign accept = creq.valid && ((state == S_IDLE) || data_valid);
    assign r_data = data_q[idx][wsel];

    // first fill word from lookup, then step on each ack
    assign fill_next = (state == S_FILL) ? fill_cnt + 1'b1 : '0;

    always_comb begin
        bus.req   = 1'b0;
        bus.we    = rq.op;
        bus.wstrb = rq.write_type;
        bus.wdata = rq.wdata;
        bus.addr  = {2'b00, rq.addr[31:2]};
        // fills walk the line from word 0
        if (!rq.op) begin
            bus.addr = {2'b00, rq.addr[31:OW+2], fill_next};
        end
        // write-through or miss start
        if (state == S_LOOKUP && (rq.op || !hit)) begin
            bus.req = 1'b1;
        end
        // next fill word as soon as the previous returns
        if (state == S_FILL && bus_ack && fill_cnt != LAST) begin
            bus.req = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            vld      <= '0;
            fill_cnt <= '0;
        end else if (data_valid) begin
            state <= accept ? S_LOOKUP : S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_LOOKUP;
                    end
                end
                // here only for a write or a read miss
                S_LOOKUP: begin
                    state    <= rq.op ? S_WRITE : S_FILL;
                    fill_cnt <= '0;
                end
                S_FILL: begin
                    if (bus_ack && fill_cnt == LAST) begin
                        // line complete, lookup again to return the word
                        state    <= S_LOOKUP;
                        vld[idx] <= 1'b1;
                    end else if (bus_ack) begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                end
                default: state <= state;
            endcase
        end
    end

    // request payload, tags and line data
    always_ff @(posedge clk) begin
        if (accept) begin
            rq <= creq;
        end
        if (state == S_FILL && bus_ack) begin
            data_q[idx][fill_cnt] <= bus_rdata;
        end
        if (state == S_FILL && bus_ack && fill_cnt == LAST) begin
            tag_q[idx] <= tag;
        end
        // write hit merges strobed bytes, a miss leaves the cache alone
        if (state == S_LOOKUP && rq.op && hit) begin
            for (int b = 0; b < 4; b++) begin
                if (rq.write_type[b]) begin
                    data_q[idx][wsel][8*b +: 8] <= rq.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== src/main_mem.sv ====
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module main_mem (
    input  logic                     clk,
    input  logic                     arst_n,
    input  mem_stage_pkg::bus_req_t  bus,
    output logic                     bus_ack,
    output logic [31:0]              bus_rdata
);
    import mem_stage_pkg::*;

    localparam int AW = $clog2(`MEM_WORDS);
    localparam int CW = $clog2(`MEM_LATENCY + 1);

    logic [31:0]   mem [`MEM_WORDS];
    bus_req_t      pend;
    logic          busy;
    logic [CW-1:0] cnt;
    logic          take;
    logic [AW-1:0] widx;

    // image rule, word a holds a*0x01010101 ^ 0xA5A5A5A5
    initial begin
        for (int a = 0; a < `MEM_WORDS; a++) begin
            mem[a] = (a * 32'h01010101) ^ 32'hA5A5A5A5;
        end
    end

    // word address wraps on the array depth
    assign widx      = pend.addr[AW-1:0];
    assign bus_ack   = busy && (cnt == '0);
    assign bus_rdata = mem[widx];
    // new req allowed once idle or on the ack cycle
    assign take      = bus.req && (!busy || bus_ack);

    // latency counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (take) begin
            busy <= 1'b1;
            cnt  <= CW'(`MEM_LATENCY - 1);
        end else if (bus_ack) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    // strobed write lands on the ack edge
    always @(posedge clk) begin
        if (take) begin
            pend <= bus;
        end
        if (bus_ack && pend.we) begin
            for (int b = 0; b < 4; b++) begin
                if (pend.wstrb[b]) begin
                    mem[widx][8*b +: 8] <= pend.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== src/mem_req.sv ====
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module mem_req (
    input  logic                       clk,
    input  logic                       arst_n,
    input  mem_stage_pkg::ex_mem_t     ex,
    input  logic                       stall,
    output mem_stage_pkg::cache_req_t  creq,
    output mem_stage_pkg::mid_t        mid
);
    import mem_stage_pkg::*;

    logic [31:0] addr;
    logic        misalign;
    logic [3:0]  strb;
    logic        go;
    mid_t        mid_d;

    // effective address
    assign addr = ex.sr + ex.imm;

    // halfword needs even address, word needs 4-byte boundary
    always_comb begin
        case (ex.width)
            `W_BYTE: misalign = 1'b0;
            `W_HALF: misalign = addr[0];
            default: misalign = |addr[1:0];
        endcase
    end

    // strobes before lane shift
    always_comb begin
        case (ex.width)
            `W_BYTE: strb = 4'b0001;
            `W_HALF: strb = 4'b0011;
            default: strb = 4'b1111;
        endcase
    end

    // real access only when enabled, clean and aligned
    assign go = ex.en && (ex.exp == `EXC_NONE) && !misalign;

    assign creq.valid      = go;
    assign creq.op         = ex.write;
    assign creq.addr       = addr;
    // move strobes and data onto the addressed byte lanes
    assign creq.write_type = strb << addr[1:0];
    assign creq.wdata      = ex.data << {addr[1:0], 3'b000};

    always_comb begin
        mid_d.rd     = ex.rd;
        mid_d.en     = ex.en;
        mid_d.access = go;
        mid_d.width  = ex.width;
        mid_d.off    = addr[1:0];
        // an earlier exception wins over misalignment
        if (ex.exp != `EXC_NONE) begin
            mid_d.exp = ex.exp;
        end else if (ex.en && misalign) begin
            mid_d.exp = `EXC_ALE;
        end else begin
            mid_d.exp = `EXC_NONE;
        end
    end

    // stage register, frozen during stall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mid <= '0;
        end else if (!stall) begin
            mid <= mid_d;
        end
    end

endmodule

// ==== src/mem_resp.sv ====
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module mem_resp (
    input  mem_stage_pkg::mid_t  mid,
    input  logic                 data_valid,
    input  logic [31:0]          r_data,
    output mem_stage_pkg::wb_t   wb,
    output logic                 stall
);
    logic [31:0] shifted;
    logic [31:0] loaded;

    // bring the addressed byte lane down to bit 0
    assign shifted = r_data >> {mid.off, 3'b000};

    // zero extend by width
    always_comb begin
        case (mid.width)
            `W_BYTE: loaded = {24'b0, shifted[7:0]};
            `W_HALF: loaded = {16'b0, shifted[15:0]};
            default: loaded = shifted;
        endcase
    end

    assign wb.exp  = mid.exp;
    assign wb.rd   = mid.rd;
    assign wb.en   = mid.en;
    // nothing read for exceptions or plain pass-through items
    assign wb.data = mid.access ? loaded : 32'b0;

    // hold upstream until the cache finishes
    assign stall = mid.access && !data_valid;

endmodule

// ==== src/mem_stage_pkg.sv ====
package mem_stage_pkg;

    // bundle from the execute stage
    typedef struct packed {
        logic [4:0]  rd;
        logic [4:0]  rk;
        logic [31:0] data;
        logic        en;
        logic [31:0] sr;
        logic [31:0] imm;
        logic        write;
        logic [1:0]  width;
        logic [6:0]  exp;
    } ex_mem_t;

    // request into the data cache
    typedef struct packed {
        // level, high while a real access is presented
        logic        valid;
        // write 1, read 0
        logic        op;
        logic [31:0] addr;
        // byte strobes, already on their lanes
        logic [3:0]  write_type;
        logic [31:0] wdata;
    } cache_req_t;

    // fields carried from request half to response half
    typedef struct packed {
        logic [6:0] exp;
        logic [4:0] rd;
        logic       en;
        // memory access outstanding
        logic       access;
        logic [1:0] width;
        // byte offset addr[1:0]
        logic [1:0] off;
    } mid_t;

    // bundle out to writeback
    typedef struct packed {
        logic [6:0]  exp;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        en;
    } wb_t;

    // cache to backing memory, word addressed
    typedef struct packed {
        logic        req;
        logic        we;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } bus_req_t;

endpackage

// ==== src/mem_stage_top.sv ====
`timescale 1ns/1ns

module mem_stage_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  mem_stage_pkg::ex_mem_t  ex,
    output mem_stage_pkg::wb_t      wb,
    output logic                    stall
);
    import mem_stage_pkg::*;

    cache_req_t  creq;
    mid_t        mid;
    logic        data_valid;
    logic [31:0] r_data;
    bus_req_t    bus;
    logic        bus_ack;
    logic [31:0] bus_rdata;

    // address, alignment and stage register
    mem_req u_req (
        .clk    (clk),
        .arst_n (arst_n),
        .ex     (ex),
        .stall  (stall),
        .creq   (creq),
        .mid    (mid)
    );

    dcache u_dcache (
        .clk        (clk),
        .arst_n     (arst_n),
        .creq       (creq),
        .data_valid (data_valid),
        .r_data     (r_data),
        .bus        (bus),
        .bus_ack    (bus_ack),
        .bus_rdata  (bus_rdata)
    );

    // fixed latency backing store
    main_mem u_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus       (bus),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata)
    );

    // load formatting and stall
    mem_resp u_resp (
        .mid        (mid),
        .data_valid (data_valid),
        .r_data     (r_data),
        .wb         (wb),
        .stall      (stall)
    );

endmodule

// ==== testbench/tb_mem_stage.sv ====
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module tb_mem_stage;
    import mem_stage_pkg::*;

    localparam int N_DIRECTED = 22;
    localparam int N_RANDOM   = 60;
    // random loads may be repeated once, reset cycles on top
    localparam int LIMIT = 40 * (N_DIRECTED + 2 * N_RANDOM + 1) + 10;

    logic        clk;
    logic        arst_n;
    ex_mem_t     ex;
    wb_t         wb;
    logic        stall;

    // byte image of backing memory, word addressed
    logic [31:0] ref_mem [`MEM_WORDS];
    wb_t         exp_q [$];
    integer      seed;
    int          errors;
    int          checked;
    int          cycles;
    int          n_items;
    bit          started;

    // item held in the stage register
    bit          cur_valid;
    bit          cur_data_chk;
    bit          cur_must_stall;
    bit          cur_no_stall;
    bit          saw_stall;
    bit          last_acc_load;

    // item retiring this cycle
    bit          chk_go;
    wb_t         chk_wb;
    bit          chk_data;
    bit          chk_must_stall;
    bit          chk_no_stall;
    bit          chk_saw;

    mem_stage_top uut (
        .clk    (clk),
        .arst_n (arst_n),
        .ex     (ex),
        .wb     (wb),
        .stall  (stall)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_value(input string name, input logic [31:0] expv,
                                input logic [31:0] act);
        errors++;
        $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expv, act);
    endtask

    task automatic report_text(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    // wait until stall drops, then retire the item in the stage
    task automatic wait_free;
        @(negedge clk);
        chk_go = 1'b0;
        while (stall) begin
            saw_stall = 1'b1;
            @(negedge clk);
        end
        if (cur_valid) begin
            chk_go         = 1'b1;
            chk_wb         = exp_q.pop_front();
            chk_data       = cur_data_chk;
            chk_must_stall = cur_must_stall;
            chk_no_stall   = cur_no_stall;
            chk_saw        = saw_stall;
            checked++;
        end
        cur_valid = 1'b0;
        saw_stall = 1'b0;
    endtask

    // hint 1 marks a cold load, hint 2 a load that has to hit
    task automatic send_item(input logic wr, input logic [1:0] w, input logic [31:0] a,
                             input logic [31:0] d, input logic [6:0] e_in,
                             input logic en_in, input int hint);
        logic        mis;
        logic        acc;
        logic [31:0] word;
        logic [31:0] imm;
        int          off;
        int          size;
        wb_t         nw;
        wait_free();
        off  = a[1:0];
        size = (w == `W_BYTE) ? 1 : (w == `W_HALF) ? 2 : 4;
        // halfword on an odd byte, word off a 4-byte boundary
        mis  = (size == 2) ? a[0] : (size == 4) ? (off != 0) : 1'b0;
        acc  = en_in && (e_in == `EXC_NONE) && !mis;
        nw.rd   = n_items[4:0];
        nw.en   = en_in;
        nw.exp  = (e_in != `EXC_NONE) ? e_in : (en_in && mis) ? `EXC_ALE : `EXC_NONE;
        nw.data = 32'b0;
        word = ref_mem[a[11:2]];
        if (acc && wr) begin
            for (int b = 0; b < 4; b++) begin
                if (b >= off && b < off + size) begin
                    word[8*b +: 8] = d[8*(b - off) +: 8];
                end
            end
            ref_mem[a[11:2]] = word;
        end
        if (acc && !wr) begin
            word = word >> (8 * off);
            nw.data = (size == 1) ? {24'b0, word[7:0]} :
                      (size == 2) ? {16'b0, word[15:0]} : word;
        end
        // split the address into base and signed offset
        imm = $random(seed);
        imm = {{24{imm[7]}}, imm[7:0]};
        ex.rd    = n_items[4:0];
        ex.rk    = 5'd0;
        ex.data  = d;
        ex.en    = en_in;
        ex.sr    = a - imm;
        ex.imm   = imm;
        ex.write = wr;
        ex.width = w;
        ex.exp   = e_in;
        exp_q.push_back(nw);
        cur_valid      = 1'b1;
        cur_data_chk   = !(acc && wr);
        cur_must_stall = acc && (wr || hint == 1);
        cur_no_stall   = !acc || hint == 2;
        last_acc_load  = acc && !wr;
        started        = 1'b1;
        n_items++;
    endtask

    // retiring item against its expected writeback bundle
    assert property (@(posedge clk) disable iff (!arst_n) chk_go |-> wb.rd == chk_wb.rd)
        else report_value("wb.rd", chk_wb.rd, $sampled(wb.rd));
    assert property (@(posedge clk) disable iff (!arst_n) chk_go |-> wb.en == chk_wb.en)
        else report_value("wb.en", chk_wb.en, $sampled(wb.en));
    assert property (@(posedge clk) disable iff (!arst_n) chk_go |-> wb.exp == chk_wb.exp)
        else report_value("wb.exp", chk_wb.exp, $sampled(wb.exp));
    assert property (@(posedge clk) disable iff (!arst_n)
                     chk_go && chk_data |-> wb.data == chk_wb.data)
        else report_value("wb.data", chk_wb.data, $sampled(wb.data));

    // quiet stage before the first item
    assert property (@(posedge clk) disable iff (!arst_n) !started |-> !stall && !wb.en)
        else report_text("stall or wb.en high before the first item");
    // stage register frozen during stall
    assert property (@(posedge clk) disable iff (!arst_n)
                     stall |=> $stable(wb.rd) && $stable(wb.en) && $stable(wb.exp))
        else report_text("wb.rd, wb.en or wb.exp changed while stall was high");
    assert property (@(posedge clk) disable iff (!arst_n) chk_go && chk_must_stall |-> chk_saw)
        else report_text("no stall seen for a store or a cold load");
    assert property (@(posedge clk) disable iff (!arst_n) chk_go && chk_no_stall |-> !chk_saw)
        else report_text("stall raised for an item that should complete at once");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, stage never drained", cycles);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        seed   = 32'ha109;
        arst_n = 1'b0;
        ex     = '0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            ref_mem[i] = (i * 32'h01010101) ^ 32'hA5A5A5A5;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // cold line, then hits on each lane and width
        send_item(0, `W_WORD, 32'h40, 0, `EXC_NONE, 1, 1);
        send_item(0, `W_WORD, 32'h44, 0, `EXC_NONE, 1, 2);
        send_item(0, `W_BYTE, 32'h41, 0, `EXC_NONE, 1, 2);
        send_item(0, `W_BYTE, 32'h42, 0, `EXC_NONE, 1, 2);
        send_item(0, `W_BYTE, 32'h43, 0, `EXC_NONE, 1, 2);
        send_item(0, `W_HALF, 32'h46, 0, `EXC_NONE, 1, 2);
        send_item(0, 2'b01, 32'h48, 0, `EXC_NONE, 1, 2);
        // store hits, then merged words from the cache
        send_item(1, `W_BYTE, 32'h4a, 32'h5c, `EXC_NONE, 1, 0);
        send_item(1, `W_HALF, 32'h4c, 32'hbeef, `EXC_NONE, 1, 0);
        send_item(0, `W_WORD, 32'h48, 0, `EXC_NONE, 1, 2);
        send_item(0, `W_WORD, 32'h4c, 0, `EXC_NONE, 1, 2);
        // store miss leaves the line out, next load still cold
        send_item(1, `W_WORD, 32'h384, 32'h12345678, `EXC_NONE, 1, 0);
        send_item(0, `W_HALF, 32'h386, 0, `EXC_NONE, 1, 1);
        // misaligned store must not reach memory
        send_item(1, `W_WORD, 32'h42, 32'hdeadbeef, `EXC_NONE, 1, 0);
        send_item(0, `W_HALF, 32'h45, 0, `EXC_NONE, 1, 0);
        send_item(0, `W_WORD, 32'h40, 0, `EXC_NONE, 1, 2);
        // evict the line, reload it from memory behind the stores
        send_item(0, `W_WORD, 32'h140, 0, `EXC_NONE, 1, 1);
        send_item(0, `W_WORD, 32'h48, 0, `EXC_NONE, 1, 1);
        send_item(0, `W_WORD, 32'h4c, 0, `EXC_NONE, 1, 2);
        send_item(0, `W_WORD, 32'h40, 0, `EXC_NONE, 1, 2);
        // earlier exception kept, then a plain idle item
        send_item(0, `W_WORD, 32'h40, 0, 7'd3, 1, 0);
        send_item(0, `W_WORD, 32'h40, 0, `EXC_NONE, 0, 0);

        // random window of two lines per set
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            a = 32'h100 + {r[12:6], 2'b00} + (r[16] ? r[15:14] : 2'b00);
            send_item(r[4] & r[5], r[1:0], a, $random(seed), `EXC_NONE, 1, 0);
            if (last_acc_load && r[20]) begin
                send_item(0, r[1:0], a, 0, `EXC_NONE, 1, 2);
            end
        end

        wait_free();
        ex = '0;
        @(negedge clk);
        chk_go = 1'b0;
        repeat (2) @(negedge clk);
        $display("checked %0d items, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
